// File: rtl/ereg_ctrl_if.sv
`timescale 1ns/10ps

interface ereg_ctrl_if;

  // decoded lifecycle state
  logic state_dealloc;
  logic state_alloc;
  logic state_retire;
  logic state_release;
  // alloc state and retire match in the same cycle
  logic retire_now;
  // producer result written back
  logic wb_done;
  // some dispatch lane creates into this entry
  logic create_vld;
  // some valid retire lane matches the held iid
  logic retire_hit;

  // lifecycle fsm side
  modport lifecycle (
    output state_dealloc, state_alloc, state_retire, state_release, retire_now,
    input  create_vld, retire_hit, wb_done
  );

  // write-back fsm side
  modport wb (
    output wb_done,
    input  create_vld, retire_now, state_dealloc, state_retire, state_release
  );

  // iid / ereg info register side
  modport info (
    output create_vld, retire_hit,
    input  retire_now
  );

endinterface

// File: rtl/ereg_entry.sv
`timescale 1ns/10ps

module ereg_entry #(
  parameter int DISP_LANES   = 4,
  parameter int RETIRE_LANES = 3
) (
  input  logic                                        sm_clk,
  input  logic                                        cpurst_b,
  // dispatch
  input  logic [DISP_LANES-1:0]                       disp_create,
  input  ereg_pkg::iid_t      [DISP_LANES-1:0]        disp_iid,
  input  ereg_pkg::ereg_idx_t [DISP_LANES-1:0]        disp_rel_ereg,
  // retire
  input  logic [RETIRE_LANES-1:0]                     retire_vld,
  input  ereg_pkg::iid_t      [RETIRE_LANES-1:0]      retire_iid,
  // control
  input  logic                                        flush,
  input  logic                                        async_flush,
  input  logic                                        sync_reset,
  input  logic                                        reset_mapped,
  input  logic                                        dealloc_vld,
  input  logic                                        release_vld,
  input  logic                                        wb_vld,
  // status
  output logic                                        cur_state_dealloc,
  output logic                                        cur_state_retire,
  output logic                                        cur_state_alloc_release,
  output ereg_pkg::ereg_mask_t                        rel_ereg_expand,
  output logic                                        retired_released_wb,
  output logic                                        retired_released_wb_for_acc
);

  // state and event bus between the three submodules
  ereg_ctrl_if ctrl_if ();

  // ==================================================
  // lifecycle
  // ==================================================
  ereg_lifecycle_fsm u_lifecycle (
    .sm_clk       (sm_clk),
    .cpurst_b     (cpurst_b),
    .flush        (flush),
    .sync_reset   (sync_reset),
    .reset_mapped (reset_mapped),
    .dealloc_vld  (dealloc_vld),
    .release_vld  (release_vld),
    .ctrl         (ctrl_if.lifecycle)
  );

  // ==================================================
  // write-back
  // ==================================================
  ereg_wb_fsm u_wb (
    .sm_clk                      (sm_clk),
    .cpurst_b                    (cpurst_b),
    .async_flush                 (async_flush),
    .sync_reset                  (sync_reset),
    .reset_mapped                (reset_mapped),
    .wb_vld                      (wb_vld),
    .ctrl                        (ctrl_if.wb),
    .retired_released_wb         (retired_released_wb),
    .retired_released_wb_for_acc (retired_released_wb_for_acc)
  );

  // ==================================================
  // producer info and release mask
  // ==================================================
  ereg_info_reg #(
    .DISP_LANES   (DISP_LANES),
    .RETIRE_LANES (RETIRE_LANES)
  ) u_info (
    .sm_clk          (sm_clk),
    .cpurst_b        (cpurst_b),
    .sync_reset      (sync_reset),
    .disp_create     (disp_create),
    .disp_iid        (disp_iid),
    .disp_rel_ereg   (disp_rel_ereg),
    .retire_vld      (retire_vld),
    .retire_iid      (retire_iid),
    .ctrl            (ctrl_if.info),
    .rel_ereg_expand (rel_ereg_expand)
  );

  // state outputs straight off the bus
  assign cur_state_dealloc       = ctrl_if.state_dealloc;
  assign cur_state_retire        = ctrl_if.state_retire;
  // rename recovery wants alloc and release merged
  assign cur_state_alloc_release = ctrl_if.state_alloc || ctrl_if.state_release;

endmodule

// File: rtl/ereg_info_reg.sv
`timescale 1ns/10ps

module ereg_info_reg #(
  parameter int DISP_LANES   = 4,
  parameter int RETIRE_LANES = 3
) (
  input  logic                                        sm_clk,
  input  logic                                        cpurst_b,
  input  logic                                        sync_reset,
  input  logic [DISP_LANES-1:0]                       disp_create,
  input  ereg_pkg::iid_t      [DISP_LANES-1:0]        disp_iid,
  input  ereg_pkg::ereg_idx_t [DISP_LANES-1:0]        disp_rel_ereg,
  input  logic [RETIRE_LANES-1:0]                     retire_vld,
  input  ereg_pkg::iid_t      [RETIRE_LANES-1:0]      retire_iid,
  ereg_ctrl_if.info                                   ctrl,
  output ereg_pkg::ereg_mask_t                        rel_ereg_expand
);

  ereg_pkg::iid_t       create_iid;
  ereg_pkg::ereg_idx_t  create_rel_ereg;
  ereg_pkg::iid_t       iid;
  ereg_pkg::ereg_idx_t  rel_ereg;
  ereg_pkg::ereg_mask_t rel_ereg_onehot;

  // ==================================================
  // dispatch create select
  // ==================================================
  assign ctrl.create_vld = |disp_create;

  // lowest active lane wins
  // walk high to low so lane 0 is written last
  always_comb begin
    create_iid      = '0;
    create_rel_ereg = '0;
    for (int i = DISP_LANES - 1; i >= 0; i--) begin
      if (disp_create[i]) begin
        create_iid      = disp_iid[i];
        create_rel_ereg = disp_rel_ereg[i];
      end
    end
  end

  // ==================================================
  // producer info register
  // ==================================================
  // iid of the producer
  // plus the ereg index it frees at retire
  always_ff @(posedge sm_clk or negedge cpurst_b) begin
    if (!cpurst_b) begin
      iid      <= '0;
      rel_ereg <= '0;
    end else if (sync_reset) begin
      iid      <= '0;
      rel_ereg <= '0;
    end else if (ctrl.create_vld) begin
      iid      <= create_iid;
      rel_ereg <= create_rel_ereg;
    end
  end

  // ==================================================
  // retire match
  // ==================================================
  always_comb begin
    ctrl.retire_hit = 1'b0;
    for (int i = 0; i < RETIRE_LANES; i++) begin
      if (retire_vld[i] && (retire_iid[i] == iid)) begin
        ctrl.retire_hit = 1'b1;
      end
    end
  end

  // ==================================================
  // release mask
  // ==================================================
  // one-hot of the held ereg index
  assign rel_ereg_onehot = ereg_pkg::ereg_mask_t'(1) << rel_ereg;

  // only while the producer retires out of alloc
  assign rel_ereg_expand = {ereg_pkg::EREG_NUM{ctrl.retire_now}} & rel_ereg_onehot;

endmodule

// File: rtl/ereg_lifecycle_fsm.sv
`timescale 1ns/10ps

module ereg_lifecycle_fsm (
  input  logic                  sm_clk,
  input  logic                  cpurst_b,
  input  logic                  flush,
  input  logic                  sync_reset,
  input  logic                  reset_mapped,
  input  logic                  dealloc_vld,
  input  logic                  release_vld,
  ereg_ctrl_if.lifecycle        ctrl
);

  ereg_pkg::lifecycle_state_e cur_state;
  ereg_pkg::lifecycle_state_e next_state;
  ereg_pkg::lifecycle_state_e reset_state;
  logic                       release_wb;

  // ==================================================
  // reset target
  // ==================================================
  // mapped eregs come up holding architectural state
  always_comb begin
    if (reset_mapped) begin
      reset_state = ereg_pkg::RETIRE;
    end else begin
      reset_state = ereg_pkg::DEALLOC;
    end
  end

  // ==================================================
  // state register
  // ==================================================
  always_ff @(posedge sm_clk or negedge cpurst_b) begin
    if (!cpurst_b) begin
      cur_state <= ereg_pkg::DEALLOC;
    end else if (sync_reset) begin
      cur_state <= reset_state;
    end else begin
      cur_state <= next_state;
    end
  end

  // release with result already written back skips RELEASE
  assign release_wb = release_vld && ctrl.wb_done;

  // ==================================================
  // next state
  // ==================================================
  always_comb begin
    next_state = cur_state;
    case (cur_state)
      ereg_pkg::DEALLOC: begin
        if (dealloc_vld && !flush) begin
          next_state = ereg_pkg::WF_ALLOC;
        end
      end
      ereg_pkg::WF_ALLOC: begin
        // flush drops the alloc register contents
        if (flush) begin
          next_state = ereg_pkg::DEALLOC;
        end else if (ctrl.create_vld) begin
          next_state = ereg_pkg::ALLOC;
        end
      end
      ereg_pkg::ALLOC: begin
        if (flush) begin
          next_state = ereg_pkg::DEALLOC;
        end else if (release_wb) begin
          next_state = ereg_pkg::DEALLOC;
        end else if (release_vld) begin
          next_state = ereg_pkg::RELEASE;
        end else if (ctrl.retire_hit) begin
          next_state = ereg_pkg::RETIRE;
        end
      end
      ereg_pkg::RETIRE: begin
        // retired eregs survive flush
        if (release_wb) begin
          next_state = ereg_pkg::DEALLOC;
        end else if (release_vld) begin
          next_state = ereg_pkg::RELEASE;
        end
      end
      ereg_pkg::RELEASE: begin
        // wait for the producer write-back
        if (ctrl.wb_done) begin
          next_state = ereg_pkg::DEALLOC;
        end
      end
      default: begin
        next_state = ereg_pkg::DEALLOC;
      end
    endcase
  end

  // ==================================================
  // state flags
  // ==================================================
  assign ctrl.state_dealloc = (cur_state == ereg_pkg::DEALLOC);
  assign ctrl.state_alloc   = (cur_state == ereg_pkg::ALLOC);
  assign ctrl.state_retire  = (cur_state == ereg_pkg::RETIRE);
  assign ctrl.state_release = (cur_state == ereg_pkg::RELEASE);

  // iid match only counts while allocated
  assign ctrl.retire_now    = ctrl.state_alloc && ctrl.retire_hit;

endmodule

// File: rtl/ereg_pkg.sv
package ereg_pkg;

  // ==================================================
  // widths
  // ==================================================
  // rob instruction id
  parameter int IID_W    = 7;
  // physical ereg index
  parameter int EREG_W   = 5;
  // one mask bit per physical ereg
  parameter int EREG_NUM = 1 << EREG_W;

  // ==================================================
  // vector types
  // ==================================================
  typedef logic [IID_W-1:0]    iid_t;
  typedef logic [EREG_W-1:0]   ereg_idx_t;
  typedef logic [EREG_NUM-1:0] ereg_mask_t;

  // ==================================================
  // state encodings
  // ==================================================
  // entry lifecycle, one-hot
  // dealloc  : free, written back, may be handed out again
  // wf_alloc : parked in the alloc register, waiting for dispatch
  // alloc    : owned by a producer in flight
  // retire   : producer retired, ereg not yet released
  // release  : released, waiting on write-back
  typedef enum logic [4:0] {
    DEALLOC  = 5'b00001,
    WF_ALLOC = 5'b00010,
    ALLOC    = 5'b00100,
    RETIRE   = 5'b01000,
    RELEASE  = 5'b10000
  } lifecycle_state_e;

  // producer write-back status
  typedef enum logic {
    IDLE = 1'b0,
    WB   = 1'b1
  } wb_state_e;

endpackage

// File: rtl/ereg_wb_fsm.sv
`timescale 1ns/10ps

module ereg_wb_fsm (
  input  logic                  sm_clk,
  input  logic                  cpurst_b,
  input  logic                  async_flush,
  input  logic                  sync_reset,
  input  logic                  reset_mapped,
  input  logic                  wb_vld,
  ereg_ctrl_if.wb               ctrl,
  output logic                  retired_released_wb,
  output logic                  retired_released_wb_for_acc
);

  ereg_pkg::wb_state_e cur_state;
  ereg_pkg::wb_state_e next_state;
  logic                retired_or_released;

  // ==================================================
  // state register
  // ==================================================
  always_ff @(posedge sm_clk or negedge cpurst_b) begin
    if (!cpurst_b) begin
      cur_state <= ereg_pkg::IDLE;
    end else if (async_flush) begin
      // everything in flight is treated as written back
      cur_state <= ereg_pkg::WB;
    end else if (sync_reset) begin
      if (reset_mapped) begin
        cur_state <= ereg_pkg::WB;
      end else begin
        cur_state <= ereg_pkg::IDLE;
      end
    end else if (ctrl.create_vld) begin
      // new producer, result pending
      cur_state <= ereg_pkg::IDLE;
    end else begin
      cur_state <= next_state;
    end
  end

  // ==================================================
  // next state
  // ==================================================
  always_comb begin
    next_state = cur_state;
    case (cur_state)
      ereg_pkg::IDLE: begin
        if (wb_vld) begin
          next_state = ereg_pkg::WB;
        end
      end
      ereg_pkg::WB: begin
        // cleared once the entry is free again
        if (ctrl.state_dealloc) begin
          next_state = ereg_pkg::IDLE;
        end
      end
      default: begin
        next_state = ereg_pkg::IDLE;
      end
    endcase
  end

  assign ctrl.wb_done = (cur_state == ereg_pkg::WB);

  // ==================================================
  // write-back flags for flush logic
  // ==================================================
  assign retired_or_released = ctrl.state_retire || ctrl.state_release;

  // retiring this cycle counts as retired
  // entries not retired or released report done
  assign retired_released_wb = (ctrl.retire_now || retired_or_released) ?
                               ctrl.wb_done : 1'b1;

  // acc update view, alloc entries read as not written back
  assign retired_released_wb_for_acc = ctrl.retire_now && (ctrl.wb_done || wb_vld)
                                    || retired_or_released && wb_vld;

endmodule

// File: include/ereg_entry_model.svh
`ifndef EREG_ENTRY_MODEL_SVH
`define EREG_ENTRY_MODEL_SVH

// lifecycle next state with sync reset folded in
function automatic ereg_pkg::lifecycle_state_e next_lifecycle(
  input ereg_pkg::lifecycle_state_e cur,
  input logic flush,
  input logic sync_reset,
  input logic reset_mapped,
  input logic dealloc_vld,
  input logic release_vld,
  input logic create_vld,
  input logic retire_hit,
  input logic wb_done
);
  ereg_pkg::lifecycle_state_e nxt;
  nxt = cur;
  case (cur)
    ereg_pkg::DEALLOC: begin
      if (dealloc_vld && !flush) begin
        nxt = ereg_pkg::WF_ALLOC;
      end
    end
    ereg_pkg::WF_ALLOC: begin
      if (flush) begin
        nxt = ereg_pkg::DEALLOC;
      end else if (create_vld) begin
        nxt = ereg_pkg::ALLOC;
      end
    end
    ereg_pkg::ALLOC: begin
      if (flush || release_vld && wb_done) begin
        nxt = ereg_pkg::DEALLOC;
      end else if (release_vld) begin
        nxt = ereg_pkg::RELEASE;
      end else if (retire_hit) begin
        nxt = ereg_pkg::RETIRE;
      end
    end
    ereg_pkg::RETIRE: begin
      if (release_vld && wb_done) begin
        nxt = ereg_pkg::DEALLOC;
      end else if (release_vld) begin
        nxt = ereg_pkg::RELEASE;
      end
    end
    ereg_pkg::RELEASE: begin
      if (wb_done) begin
        nxt = ereg_pkg::DEALLOC;
      end
    end
    default: begin
      nxt = ereg_pkg::DEALLOC;
    end
  endcase
  if (sync_reset) begin
    nxt = reset_mapped ? ereg_pkg::RETIRE : ereg_pkg::DEALLOC;
  end
  return nxt;
endfunction

// write-back next state in priority order
function automatic ereg_pkg::wb_state_e next_wb_state(
  input ereg_pkg::wb_state_e cur,
  input logic async_flush,
  input logic sync_reset,
  input logic reset_mapped,
  input logic create_vld,
  input logic wb_vld,
  input logic in_dealloc
);
  if (async_flush) return ereg_pkg::WB;
  if (sync_reset) return reset_mapped ? ereg_pkg::WB : ereg_pkg::IDLE;
  if (create_vld) return ereg_pkg::IDLE;
  if (cur == ereg_pkg::IDLE) return wb_vld ? ereg_pkg::WB : ereg_pkg::IDLE;
  return in_dealloc ? ereg_pkg::IDLE : ereg_pkg::WB;
endfunction

// expected release mask
// one bit set at the held index
function automatic ereg_pkg::ereg_mask_t expected_release_mask(
  input ereg_pkg::ereg_idx_t idx,
  input logic retire_now
);
  ereg_pkg::ereg_mask_t mask;
  mask = '0;
  if (retire_now) begin
    mask[idx] = 1'b1;
  end
  return mask;
endfunction

`endif

// File: tb/tb_ereg_entry.sv
`timescale 1ns/10ps

module tb_ereg_entry;

  localparam int DISP_LANES     = 4;
  localparam int RETIRE_LANES   = 3;
  localparam int RESET_CYCLES   = 8;
  localparam int TEST_CYCLES    = 2000;
  // reset plus random phase plus slack for the final checks
  localparam int TIMEOUT_CYCLES = RESET_CYCLES + TEST_CYCLES + 192;

  logic                                   sm_clk;
  logic                                   cpurst_b;
  logic [DISP_LANES-1:0]                  disp_create;
  ereg_pkg::iid_t      [DISP_LANES-1:0]   disp_iid;
  ereg_pkg::ereg_idx_t [DISP_LANES-1:0]   disp_rel_ereg;
  logic [RETIRE_LANES-1:0]                retire_vld;
  ereg_pkg::iid_t      [RETIRE_LANES-1:0] retire_iid;
  logic                                   flush;
  logic                                   async_flush;
  logic                                   sync_reset;
  logic                                   reset_mapped;
  logic                                   dealloc_vld;
  logic                                   release_vld;
  logic                                   wb_vld;
  logic                                   cur_state_dealloc;
  logic                                   cur_state_retire;
  logic                                   cur_state_alloc_release;
  ereg_pkg::ereg_mask_t                   rel_ereg_expand;
  logic                                   retired_released_wb;
  logic                                   retired_released_wb_for_acc;

  // reference model state
  ereg_pkg::lifecycle_state_e model_lc;
  ereg_pkg::wb_state_e        model_wb;
  ereg_pkg::iid_t             model_iid;
  ereg_pkg::ereg_idx_t        model_rel;

  logic [31:0] lfsr;
  int          cycle_count;
  int          hit_count;
  int          release_count;

  `include "ereg_entry_model.svh"

  ereg_entry #(
    .DISP_LANES   (DISP_LANES),
    .RETIRE_LANES (RETIRE_LANES)
  ) UUT (
    .sm_clk                      (sm_clk),
    .cpurst_b                    (cpurst_b),
    .disp_create                 (disp_create),
    .disp_iid                    (disp_iid),
    .disp_rel_ereg               (disp_rel_ereg),
    .retire_vld                  (retire_vld),
    .retire_iid                  (retire_iid),
    .flush                       (flush),
    .async_flush                 (async_flush),
    .sync_reset                  (sync_reset),
    .reset_mapped                (reset_mapped),
    .dealloc_vld                 (dealloc_vld),
    .release_vld                 (release_vld),
    .wb_vld                      (wb_vld),
    .cur_state_dealloc           (cur_state_dealloc),
    .cur_state_retire            (cur_state_retire),
    .cur_state_alloc_release     (cur_state_alloc_release),
    .rel_ereg_expand             (rel_ereg_expand),
    .retired_released_wb         (retired_released_wb),
    .retired_released_wb_for_acc (retired_released_wb_for_acc)
  );

  // 40 ns period
  always #20 sm_clk = ~sm_clk;

  // ==================================================
  // random source
  // ==================================================
  // taps 32 22 2 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  // one lfsr step per bit
  function automatic logic [31:0] draw_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_next(lfsr);
      r    = {r[30:0], lfsr[0]};
    end
    return r;
  endfunction

  // ==================================================
  // compare tasks
  // ==================================================
  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("FAIL t=%0t %s got=%b exp=%b", $time, name, got, exp);
      $display("SIMULATION FAILED");
      $fatal(1);
    end
  endtask

  task automatic check_mask(input string name, input ereg_pkg::ereg_mask_t got,
                            input ereg_pkg::ereg_mask_t exp);
    if (got !== exp) begin
      $display("FAIL t=%0t %s got=%h exp=%h", $time, name, got, exp);
      $display("SIMULATION FAILED");
      $fatal(1);
    end
  endtask

  // any valid retire lane carrying the held iid
  function automatic logic match_retire(input logic [RETIRE_LANES-1:0] vld,
                                        input ereg_pkg::iid_t [RETIRE_LANES-1:0] iids,
                                        input ereg_pkg::iid_t held);
    logic hit;
    hit = 1'b0;
    for (int i = 0; i < RETIRE_LANES; i++) begin
      hit = hit | (vld[i] & (iids[i] == held));
    end
    return hit;
  endfunction

  // ==================================================
  // model, predict and advance
  // ==================================================
  task automatic reset_model();
    model_lc  = ereg_pkg::DEALLOC;
    model_wb  = ereg_pkg::IDLE;
    model_iid = '0;
    model_rel = '0;
  endtask

  task automatic check_outputs();
    logic now;
    logic rr;
    logic done;
    now  = (model_lc == ereg_pkg::ALLOC) && match_retire(retire_vld, retire_iid, model_iid);
    rr   = (model_lc == ereg_pkg::RETIRE) || (model_lc == ereg_pkg::RELEASE);
    done = (model_wb == ereg_pkg::WB);
    if (now) begin
      hit_count++;
    end
    check_flag("cur_state_dealloc", cur_state_dealloc, model_lc == ereg_pkg::DEALLOC);
    check_flag("cur_state_retire", cur_state_retire, model_lc == ereg_pkg::RETIRE);
    check_flag("cur_state_alloc_release", cur_state_alloc_release,
               (model_lc == ereg_pkg::ALLOC) || (model_lc == ereg_pkg::RELEASE));
    check_mask("rel_ereg_expand", rel_ereg_expand, expected_release_mask(model_rel, now));
    check_flag("retired_released_wb", retired_released_wb, (now || rr) ? done : 1'b1);
    check_flag("retired_released_wb_for_acc", retired_released_wb_for_acc,
               (now && (done || wb_vld)) || (rr && wb_vld));
  endtask

  task automatic advance_model();
    logic                       create;
    logic                       hit;
    int                         lane;
    ereg_pkg::lifecycle_state_e lc_nxt;
    ereg_pkg::wb_state_e        wb_nxt;
    create = |disp_create;
    hit    = match_retire(retire_vld, retire_iid, model_iid);
    lane   = -1;
    if (model_lc == ereg_pkg::RELEASE && model_wb == ereg_pkg::WB && !sync_reset) begin
      release_count++;
    end
    lc_nxt = next_lifecycle(model_lc, flush, sync_reset, reset_mapped, dealloc_vld,
                            release_vld, create, hit, model_wb == ereg_pkg::WB);
    wb_nxt = next_wb_state(model_wb, async_flush, sync_reset, reset_mapped, create, wb_vld,
                           model_lc == ereg_pkg::DEALLOC);
    for (int i = 0; i < DISP_LANES; i++) begin
      if (disp_create[i] && lane < 0) begin
        lane = i;
      end
    end
    if (sync_reset) begin
      model_iid = '0;
      model_rel = '0;
    end else if (create) begin
      model_iid = disp_iid[lane];
      model_rel = disp_rel_ereg[lane];
    end
    model_lc = lc_nxt;
    model_wb = wb_nxt;
  endtask

  // outputs settle between edges so check at the falling edge
  always @(negedge sm_clk) begin
    // the x to 0 step of the clock at time zero is no real edge
    if (cycle_count > 0) begin
      if (!cpurst_b) begin
        reset_model();
      end
      check_outputs();
      if (cpurst_b) begin
        advance_model();
      end
    end
  end

  // ==================================================
  // stimulus
  // ==================================================
  task automatic drive_random();
    logic [DISP_LANES-1:0] create_bits;
    create_bits = '0;
    if (draw_bits(1)) begin
      create_bits = {{(DISP_LANES - 1){1'b0}}, 1'b1} << draw_bits(2);
    end
    disp_create <= create_bits;
    for (int i = 0; i < DISP_LANES; i++) begin
      // small iid range so retire matches are common
      disp_iid[i]      <= ereg_pkg::iid_t'(draw_bits(3));
      disp_rel_ereg[i] <= ereg_pkg::ereg_idx_t'(draw_bits(ereg_pkg::EREG_W));
    end
    for (int i = 0; i < RETIRE_LANES; i++) begin
      retire_vld[i] <= draw_bits(2) != 0;
      retire_iid[i] <= ereg_pkg::iid_t'(draw_bits(3));
    end
    // rare controls
    sync_reset   <= draw_bits(6) == 0;
    flush        <= draw_bits(5) == 0;
    async_flush  <= draw_bits(6) == 0;
    reset_mapped <= draw_bits(1) != 0;
    // frequent pulses
    dealloc_vld  <= draw_bits(2) != 0;
    release_vld  <= draw_bits(2) == 0;
    wb_vld       <= draw_bits(2) == 0;
  endtask

  // hang guard
  always @(posedge sm_clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("timeout, run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("SIMULATION FAILED");
      $fatal(1);
    end
  end

  initial begin
    lfsr          = 32'he184e380;
    sm_clk        = 1'b0;
    cpurst_b      = 1'b0;
    cycle_count   = 0;
    hit_count     = 0;
    release_count = 0;
    disp_create   = '0;
    disp_iid      = '0;
    disp_rel_ereg = '0;
    retire_vld    = '0;
    retire_iid    = '0;
    flush         = 1'b0;
    async_flush   = 1'b0;
    sync_reset    = 1'b0;
    reset_mapped  = 1'b0;
    dealloc_vld   = 1'b0;
    release_vld   = 1'b0;
    wb_vld        = 1'b0;
    reset_model();
    repeat (RESET_CYCLES) @(posedge sm_clk);
    cpurst_b <= 1'b1;
    repeat (TEST_CYCLES) begin
      @(posedge sm_clk);
      drive_random();
    end
    // let the last cycle be checked
    @(negedge sm_clk);
    @(posedge sm_clk);
    if (hit_count == 0 || release_count == 0) begin
      $display("retire match or release write-back path was never exercised");
      $display("SIMULATION FAILED");
      $fatal(1);
    end else begin
      $display("SIMULATION PASSED");
      $finish;
    end
  end

endmodule

// File: verilog.f
+incdir+include
rtl/ereg_pkg.sv
rtl/ereg_ctrl_if.sv
rtl/ereg_lifecycle_fsm.sv
rtl/ereg_wb_fsm.sv
rtl/ereg_info_reg.sv
rtl/ereg_entry.sv
tb/tb_ereg_entry.sv
